/* source/rv_core_settings.svh */
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data and address width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_REG_COUNT 32

// address of the first fetch after reset.
`define RV_RESET_PC 32'h0000_0000

// pc step between sequential instructions.
`define RV_INSTR_BYTES 32'd4

`endif

/* source/rv_core_pkg.sv */
`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // slt and sltu go through the comparator instead.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } alu_op_t;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_CMP,
        WB_PC4,
        WB_LOAD
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_t     opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } instr_j_t;

    // one fetched word, seen in every format.
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_word_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        alu_op_t    alu_op;
        logic       op_a_pc;
        logic       op_b_imm;
        wb_sel_t    wb_sel;
        logic       we;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_store;
    } ctrl_word_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        ctrl_word_t ctrl;
        word_t      imm;
        word_t      rs1_val;
        word_t      rs2_val;
    } dec_bundle_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        ctrl_word_t ctrl;
        word_t      alu_res;
        logic       cmp;
        word_t      store_data;
    } exe_bundle_t;

    typedef struct packed {
        logic       read;
        logic       write;
        logic [3:0] byte_en;
        word_t      addr;
        word_t      wdata;
    } dmem_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_bus_t;

endpackage

/* source/rv_fetch.sv */
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module rv_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  rv_core_pkg::word_t        redirect_pc,
    input  rv_core_pkg::word_t        inst_rdata,
    output rv_core_pkg::word_t        inst_addr,
    output rv_core_pkg::word_t        fetch_pc,
    output rv_core_pkg::instr_word_t  fetch_instr,
    output logic                      fetch_valid
);
    import rv_core_pkg::*;

    word_t pc_next;

    // always predicts not taken.
    assign pc_next = redirect ? redirect_pc : inst_addr + `RV_INSTR_BYTES;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_addr   <= `RV_RESET_PC;
            fetch_valid <= 1'b0;
        end else if (!stall) begin
            inst_addr   <= pc_next;
            fetch_valid <= !redirect; // wrong-path word dropped.
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_pc    <= inst_addr;
            fetch_instr <= instr_word_t'(inst_rdata);
        end
    end

    // redirect targets from execute must keep fetch word aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_addr[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", inst_addr);

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_core_pkg::wb_bus_t    wb,
    input  rv_core_pkg::reg_addr_t  rs1,
    input  rv_core_pkg::reg_addr_t  rs2,
    output rv_core_pkg::word_t      rs1_data,
    output rv_core_pkg::word_t      rs2_data
);
    import rv_core_pkg::*;

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `RV_REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so decode sees the value retiring this cycle.
    always_comb begin
        rs1_data = regs[rs1];
        rs2_data = regs[rs2];
        if (wb.we && wb.rd == rs1) rs1_data = wb.data;
        if (wb.we && wb.rd == rs2) rs2_data = wb.data;
        if (rs1 == '0) rs1_data = '0; // x0 is hardwired.
        if (rs2 == '0) rs2_data = '0;
    end

endmodule

/* source/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    input  rv_core_pkg::word_t        fetch_pc,
    input  rv_core_pkg::instr_word_t  fetch_instr,
    input  logic                      fetch_valid,
    input  rv_core_pkg::word_t        rs1_data,
    input  rv_core_pkg::word_t        rs2_data,
    output rv_core_pkg::reg_addr_t    rs1,
    output rv_core_pkg::reg_addr_t    rs2,
    output rv_core_pkg::dec_bundle_t  dec
);
    import rv_core_pkg::*;

    ctrl_word_t  ctrl;
    word_t       imm;
    logic        known;
    dec_bundle_t dec_d;

    assign rs1 = fetch_instr.r.rs1;
    assign rs2 = fetch_instr.r.rs2;

    // immediate in the format the opcode selects.
    always_comb begin
        unique case (fetch_instr.r.opcode)
            OP_STORE: imm = {{20{fetch_instr.s.imm_hi[6]}}, fetch_instr.s.imm_hi,
                             fetch_instr.s.imm_lo};
            OP_BRANCH: imm = {{20{fetch_instr.b.imm12}}, fetch_instr.b.imm11,
                              fetch_instr.b.imm10_5, fetch_instr.b.imm4_1, 1'b0};
            OP_LUI, OP_AUIPC: imm = {fetch_instr.u.imm, 12'b0};
            OP_JAL: imm = {{12{fetch_instr.j.imm20}}, fetch_instr.j.imm19_12,
                           fetch_instr.j.imm11, fetch_instr.j.imm10_1, 1'b0};
            default: imm = {{20{fetch_instr.i.imm[11]}}, fetch_instr.i.imm};
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = fetch_instr.r.opcode;
        ctrl.funct3 = fetch_instr.r.funct3;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        ctrl.rd     = fetch_instr.r.rd;
        ctrl.rs1    = fetch_instr.r.rs1;
        ctrl.rs2    = fetch_instr.r.rs2;
        known       = 1'b1;
        unique case (fetch_instr.r.opcode)
            OP_LUI: begin
                ctrl.alu_op   = ALU_COPY_B;
                ctrl.op_b_imm = 1'b1;
                ctrl.we       = 1'b1;
            end
            OP_AUIPC: begin
                ctrl.op_a_pc  = 1'b1;
                ctrl.op_b_imm = 1'b1;
                ctrl.we       = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                ctrl.is_jal  = fetch_instr.r.opcode == OP_JAL;
                ctrl.is_jalr = fetch_instr.r.opcode == OP_JALR;
                ctrl.wb_sel  = WB_PC4;
                ctrl.we      = 1'b1;
            end
            OP_BRANCH: ctrl.is_branch = 1'b1;
            OP_LOAD: begin
                ctrl.op_b_imm = 1'b1;
                ctrl.is_load  = 1'b1;
                ctrl.wb_sel   = WB_LOAD;
                ctrl.we       = 1'b1;
            end
            OP_STORE: begin
                ctrl.op_b_imm = 1'b1;
                ctrl.is_store = 1'b1;
            end
            OP_IMM, OP_REG: begin
                ctrl.op_b_imm = fetch_instr.r.opcode == OP_IMM;
                ctrl.we       = 1'b1;
                unique case (fetch_instr.r.funct3)
                    3'b000: begin
                        if (!ctrl.op_b_imm && fetch_instr.r.funct7[5]) ctrl.alu_op = ALU_SUB;
                    end
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010, 3'b011: ctrl.wb_sel = WB_CMP; // slt, sltu.
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = fetch_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        dec_d.valid   = fetch_valid && !flush && known;
        dec_d.pc      = fetch_pc;
        dec_d.ctrl    = ctrl;
        dec_d.imm     = imm;
        dec_d.rs1_val = rs1_data;
        dec_d.rs2_val = rs2_data;
    end

    always_ff @(posedge clk) begin
        if (!stall) dec <= dec_d;
        if (rst) dec.valid <= 1'b0;
    end

    // fetch must never hand over a word outside RV32I.
    a_known_opcode: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !flush && !stall |-> known)
        else $error("unknown opcode %b at pc %h", fetch_instr.r.opcode, fetch_pc);

endmodule

/* source/rv_execute.sv */
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module rv_execute (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  rv_core_pkg::dec_bundle_t  dec,
    input  rv_core_pkg::wb_bus_t      wb,
    output logic                      redirect,
    output rv_core_pkg::word_t        redirect_pc,
    output rv_core_pkg::exe_bundle_t  exe
);
    import rv_core_pkg::*;

    word_t       rs1_val;
    word_t       rs2_val;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_out;
    word_t       target;
    word_t       link;
    logic [4:0]  shamt;
    logic        cmp;
    logic        taken;
    exe_bundle_t exe_d;

    // forward the retiring result over stale register reads.
    always_comb begin
        rs1_val = dec.rs1_val;
        rs2_val = dec.rs2_val;
        if (wb.we && wb.rd != '0 && wb.rd == dec.ctrl.rs1) rs1_val = wb.data;
        if (wb.we && wb.rd != '0 && wb.rd == dec.ctrl.rs2) rs2_val = wb.data;
    end

    assign op_a  = dec.ctrl.op_a_pc ? dec.pc : rs1_val;
    assign op_b  = dec.ctrl.op_b_imm ? dec.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (dec.ctrl.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_COPY_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // shared by branches and slt/sltu.
    always_comb begin
        unique case (dec.ctrl.funct3)
            3'b000:         cmp = rs1_val == op_b;
            3'b001:         cmp = rs1_val != op_b;
            3'b100, 3'b010: cmp = $signed(rs1_val) < $signed(op_b);
            3'b101:         cmp = $signed(rs1_val) >= $signed(op_b);
            3'b110, 3'b011: cmp = rs1_val < op_b;
            default:        cmp = rs1_val >= op_b;
        endcase
    end

    assign taken       = dec.ctrl.is_jal || dec.ctrl.is_jalr || (dec.ctrl.is_branch && cmp);
    assign target      = (dec.ctrl.is_jalr ? rs1_val : dec.pc) + dec.imm;
    assign redirect_pc = {target[`RV_XLEN-1:1], 1'b0}; // jalr drops bit 0.
    assign redirect    = dec.valid && taken && !stall;
    assign link        = dec.pc + `RV_INSTR_BYTES;

    always_comb begin
        exe_d.valid      = dec.valid;
        exe_d.pc         = dec.pc;
        exe_d.ctrl       = dec.ctrl;
        exe_d.alu_res    = (dec.ctrl.is_jal || dec.ctrl.is_jalr) ? link : alu_out;
        exe_d.cmp        = cmp;
        exe_d.store_data = rs2_val << {alu_out[1:0], 3'b000}; // into its byte lanes.
    end

    always_ff @(posedge clk) begin
        if (!stall) exe <= exe_d;
        if (rst) exe.valid <= 1'b0;
    end

endmodule

/* source/rv_result.sv */
`timescale 1ns/100ps

module rv_result (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_core_pkg::exe_bundle_t  exe,
    input  logic                      data_resp,
    input  rv_core_pkg::word_t        data_rdata,
    output rv_core_pkg::dmem_req_t    data_req,
    output logic                      stall,
    output rv_core_pkg::wb_bus_t      wb
);
    import rv_core_pkg::*;

    logic       mem_op;
    logic [3:0] byte_en;
    word_t      lane;
    word_t      load_val;

    assign mem_op = exe.valid && (exe.ctrl.is_load || exe.ctrl.is_store);
    assign stall  = mem_op && !data_resp;

    always_comb begin
        unique case (exe.ctrl.funct3[1:0])
            2'b00:   byte_en = 4'b0001 << exe.alu_res[1:0];
            2'b01:   byte_en = 4'b0011 << {exe.alu_res[1], 1'b0};
            default: byte_en = 4'b1111;
        endcase
    end

    // exe register holds during the wait, so the request stays put.
    always_comb begin
        data_req.read    = exe.valid && exe.ctrl.is_load;
        data_req.write   = exe.valid && exe.ctrl.is_store;
        data_req.byte_en = byte_en;
        data_req.addr    = {exe.alu_res[31:2], 2'b00};
        data_req.wdata   = exe.store_data;
    end

    assign lane = data_rdata >> {exe.alu_res[1:0], 3'b000};

    always_comb begin
        unique case (exe.ctrl.funct3)
            3'b000:  load_val = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_val = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_val = {24'b0, lane[7:0]};
            3'b101:  load_val = {16'b0, lane[15:0]};
            default: load_val = data_rdata;
        endcase
    end

    always_comb begin
        wb.we = exe.valid && exe.ctrl.we && !stall; // only when it completes.
        wb.rd = exe.ctrl.rd;
        unique case (exe.ctrl.wb_sel)
            WB_CMP:  wb.data = {31'b0, exe.cmp};
            WB_LOAD: wb.data = load_val;
            default: wb.data = exe.alu_res;
        endcase
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(data_req.read && data_req.write))
        else $error("data read and write raised together");

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(data_req))
        else $error("data request changed while waiting for data_resp");

endmodule

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    inst_read,
    output rv_core_pkg::word_t      inst_addr,
    input  logic                    inst_resp,
    input  rv_core_pkg::word_t      inst_rdata,
    output rv_core_pkg::dmem_req_t  data_req,
    input  logic                    data_resp,
    input  rv_core_pkg::word_t      data_rdata
);
    import rv_core_pkg::*;

    word_t       fetch_pc;
    instr_word_t fetch_instr;
    logic        fetch_valid;
    logic        redirect;
    word_t       redirect_pc;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       rs1_data;
    word_t       rs2_data;
    dec_bundle_t dec;
    exe_bundle_t exe;
    wb_bus_t     wb;
    logic        res_stall;
    logic        stall;

    assign inst_read = 1'b1;
    assign stall     = res_stall || !inst_resp; // freezes every stage.

    rv_fetch rv_fetch_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_rdata  (inst_rdata),
        .inst_addr   (inst_addr),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_valid (fetch_valid)
    );

    rv_regfile rv_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_decode rv_decode_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (redirect),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_valid (fetch_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .dec         (dec)
    );

    rv_execute rv_execute_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .dec         (dec),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exe         (exe)
    );

    rv_result rv_result_i (
        .clk        (clk),
        .rst        (rst),
        .exe        (exe),
        .data_resp  (data_resp),
        .data_rdata (data_rdata),
        .data_req   (data_req),
        .stall      (res_stall),
        .wb         (wb)
    );

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int    imem_words      = 256;
    localparam int    max_wait        = 8;
    localparam int    margin          = 4;
    localparam int    run_count       = 8;
    localparam int    watchdog_cycles = run_count * imem_words * max_wait * margin;
    localparam word_t done_addr       = 32'h0000_03FC;
    localparam word_t store_base      = 32'h0000_0100;
    localparam word_t poison_addr     = 32'h0000_01C0;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      inst_read;
    word_t     inst_addr;
    logic      inst_resp = 1'b0;
    word_t     inst_rdata = '0;
    dmem_req_t data_req;
    logic      data_resp = 1'b0;
    word_t     data_rdata = '0;

    word_t     imem [imem_words];
    word_t     dmem [imem_words];
    word_t     prog [$];
    dmem_req_t expect_q [$];
    dmem_req_t seen_q [$];
    int        gap;
    int        store_off;
    int        errors;
    int        checks;
    logic      random_delay;
    logic      done_seen;
    logic [15:0] lfsr;
    logic [2:0] branch_funct3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    rv_core rv_core_i (
        .clk        (clk),
        .rst        (rst),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_resp  (data_resp),
        .data_rdata (data_rdata)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t fill_word(input int idx);
        fill_word = word_t'(idx + 1) * 32'h9E37_79B9;
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        enc_i = {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
        enc_u = {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  branch_taken = a == b;
            3'b001:  branch_taken = a != b;
            3'b100:  branch_taken = $signed(a) < $signed(b);
            3'b101:  branch_taken = $signed(a) >= $signed(b);
            3'b110:  branch_taken = a < b;
            default: branch_taken = a >= b;
        endcase
    endfunction

    function automatic dmem_req_t make_req(input word_t addr, input logic [3:0] be,
                                           input word_t data);
        make_req.read    = 1'b0;
        make_req.write   = 1'b1;
        make_req.byte_en = be;
        make_req.addr    = addr;
        make_req.wdata   = data;
    endfunction

    // memory model answers both ports on the falling edge.
    always @(negedge clk) begin
        inst_rdata = imem[inst_addr[9:2]];
        data_rdata = dmem[data_req.addr[9:2]];
        inst_resp  = 1'b1;
        if (random_delay) begin
            inst_resp = lfsr[15];
            lfsr      = lfsr_next(lfsr);
        end
        data_resp = data_req.read || data_req.write;
        if (random_delay && data_resp) begin
            data_resp = lfsr[15];
            lfsr      = lfsr_next(lfsr);
        end
    end

    // a store completes on the edge where nothing stalls.
    always @(posedge clk) begin
        if (!rst && data_req.write && data_resp && inst_resp) begin
            for (int k = 0; k < 4; k++) begin
                if (data_req.byte_en[k]) begin
                    dmem[data_req.addr[9:2]][8*k +: 8] = data_req.wdata[8*k +: 8];
                end
            end
            if (data_req.addr == done_addr) done_seen = 1'b1;
            else seen_q.push_back(data_req);
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input dmem_req_t got, input dmem_req_t exp);
        word_t mask;
        mask = {{8{exp.byte_en[3]}}, {8{exp.byte_en[2]}}, {8{exp.byte_en[1]}},
                {8{exp.byte_en[0]}}};
        checks++;
        if (got.read !== exp.read || got.write !== exp.write || got.byte_en !== exp.byte_en
            || got.addr !== exp.addr || (got.wdata & mask) !== (exp.wdata & mask)) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic emit_op(input word_t w);
        emit(w);
        repeat (gap) emit(32'h0000_0013); // nop spacing.
    endtask

    task automatic store_reg(input reg_addr_t r, input word_t exp);
        emit_op(enc_s(12'(store_off), r, 5'd10, 3'b010));
        expect_q.push_back(make_req(store_base + word_t'(store_off), 4'hF, exp));
        store_off += 4;
    endtask

    task automatic begin_program();
        prog.delete();
        expect_q.delete();
        store_off = 0;
        emit_op(enc_i(12'h100, 5'd0, 3'b000, 5'd10, OP_IMM));
        emit_op(enc_i(12'hFFB, 5'd0, 3'b000, 5'd1, OP_IMM)); // x1 = -5.
        emit_op(enc_i(12'h003, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit_op(enc_i(12'h200, 5'd0, 3'b000, 5'd11, OP_IMM));
        emit_op(enc_i(12'h040, 5'd0, 3'b000, 5'd12, OP_IMM));
        emit_op(enc_u(20'h87654, 5'd4, OP_LUI));
        emit_op(enc_i(12'h321, 5'd4, 3'b000, 5'd4, OP_IMM));
    endtask

    task automatic finish_program();
        emit(enc_s(done_addr[11:0], 5'd0, 5'd0, 3'b010));
        emit(enc_j(21'd0, 5'd0)); // spin here.
    endtask

    task automatic op_case(input word_t instr, input word_t exp);
        emit_op(instr);
        store_reg(5'd3, exp);
    endtask

    task automatic alu_program();
        word_t a;
        word_t b;
        word_t pc;
        a = 32'hFFFF_FFFB;
        b = 32'd3;
        begin_program();
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
        op_case(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
        emit_op(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        op_case(enc_r(7'h00, 5'd3, 5'd3, 3'b000, 5'd3), (a - b) + (a - b));
        emit_op(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        emit_op(enc_i(12'h001, 5'd2, 3'b000, 5'd6, OP_IMM)); // reader two slots behind.
        op_case(enc_r(7'h00, 5'd3, 5'd3, 3'b000, 5'd3), (a - b) + (a - b));
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), a << 3);
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), {31'b0, $signed(a) < $signed(b)});
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), {31'b0, a < b});
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), a >> 3);
        op_case(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), word_t'($signed(a) >>> 3));
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
        op_case(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
        op_case(enc_i(12'h07F, 5'd1, 3'b100, 5'd3, OP_IMM), a ^ 32'h7F);
        op_case(enc_i(12'h7F0, 5'd2, 3'b110, 5'd3, OP_IMM), b | 32'h7F0);
        op_case(enc_i(12'h00F, 5'd1, 3'b111, 5'd3, OP_IMM), a & 32'hF);
        op_case(enc_i(12'hFFC, 5'd1, 3'b010, 5'd3, OP_IMM), {31'b0, $signed(a) < -4});
        op_case(enc_i(12'hFFF, 5'd2, 3'b011, 5'd3, OP_IMM), {31'b0, b < 32'hFFFF_FFFF});
        op_case(enc_i(12'h004, 5'd1, 3'b001, 5'd3, OP_IMM), a << 4);
        op_case(enc_i(12'h01C, 5'd1, 3'b101, 5'd3, OP_IMM), a >> 28);
        op_case(enc_i(12'h401, 5'd1, 3'b101, 5'd3, OP_IMM), word_t'($signed(a) >>> 1));
        op_case(enc_u(20'hABCDE, 5'd3, OP_LUI), 32'hABCD_E000);
        pc = word_t'(prog.size() * 4);
        op_case(enc_u(20'h00012, 5'd3, OP_AUIPC), pc + 32'h0001_2000);
        finish_program();
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, input word_t a,
                               input reg_addr_t rs2, input word_t b);
        emit(enc_b(13'd12, rs2, rs1, f3));
        emit(enc_s(12'h0C0, 5'd0, 5'd10, 3'b010)); // shadow stores.
        emit(enc_s(12'h0C0, 5'd0, 5'd10, 3'b010));
        if (!branch_taken(f3, a, b)) begin
            expect_q.push_back(make_req(poison_addr, 4'hF, '0));
            expect_q.push_back(make_req(poison_addr, 4'hF, '0));
        end
    endtask

    task automatic branch_program();
        word_t a;
        word_t b;
        word_t p;
        a = 32'hFFFF_FFFB;
        b = 32'd3;
        begin_program();
        foreach (branch_funct3[n]) branch_case(branch_funct3[n], 5'd1, a, 5'd2, b);
        branch_case(3'b000, 5'd1, a, 5'd1, a);
        p = word_t'(prog.size() * 4);
        emit(enc_j(21'd12, 5'd5));
        emit(enc_s(12'h0C0, 5'd0, 5'd10, 3'b010));
        emit(enc_s(12'h0C0, 5'd0, 5'd10, 3'b010));
        store_reg(5'd5, p + 32'd4);
        p = word_t'(prog.size() * 4);
        emit(enc_u(20'h0, 5'd6, OP_AUIPC));
        emit(enc_i(12'd13, 5'd6, 3'b000, 5'd7, OP_JALR)); // odd target loses bit 0.
        emit(enc_s(12'h0C0, 5'd0, 5'd10, 3'b010));
        store_reg(5'd7, p + 32'd8);
        finish_program();
    endtask

    task automatic load_case(input logic [2:0] f3, input int k, input word_t exp);
        emit_op(enc_i(12'(k), 5'd12, f3, 5'd3, OP_LOAD));
        store_reg(5'd3, exp);
    endtask

    task automatic memory_program();
        word_t v;
        word_t w;
        v = 32'h8765_4321;
        w = fill_word(16);
        begin_program();
        for (int k = 0; k < 4; k++) begin
            emit_op(enc_s(12'(k), 5'd4, 5'd11, 3'b000));
            expect_q.push_back(make_req(32'h200, 4'b0001 << k, v << (8 * k)));
        end
        for (int k = 0; k < 4; k += 2) begin
            emit_op(enc_s(12'(k), 5'd4, 5'd11, 3'b001));
            expect_q.push_back(make_req(32'h200, 4'b0011 << k, v << (8 * k)));
        end
        emit_op(enc_s(12'h0, 5'd4, 5'd11, 3'b010));
        expect_q.push_back(make_req(32'h200, 4'hF, v));
        for (int k = 0; k < 4; k++) begin
            load_case(3'b000, k, {{24{w[8*k+7]}}, w[8*k +: 8]});
            load_case(3'b100, k, {24'b0, w[8*k +: 8]});
        end
        for (int k = 0; k < 4; k += 2) begin
            load_case(3'b001, k, {{16{w[8*k+15]}}, w[8*k +: 16]});
            load_case(3'b101, k, {16'b0, w[8*k +: 16]});
        end
        load_case(3'b010, 0, w);
        finish_program();
    endtask

    task automatic run_program(input string name);
        int n;
        @(negedge clk);
        rst = 1'b1;
        if (prog.size() > imem_words) begin
            errors++;
            $display("%s: program does not fit in instruction memory", name);
        end
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, OP_IMM);
            dmem[i] = fill_word(i);
        end
        foreach (prog[i]) imem[i] = prog[i];
        seen_q.delete();
        done_seen = 1'b0;
        repeat (3) @(negedge clk);
        check_word({name, " inst_addr after reset"}, inst_addr, `RV_RESET_PC);
        check_word({name, " data_req read/write after reset"},
                   {30'b0, data_req.read, data_req.write}, '0);
        check_word({name, " inst_read"}, word_t'(inst_read), 32'd1);
        rst = 1'b0;
        wait (done_seen);
        check_word({name, " store count"}, word_t'(seen_q.size()), word_t'(expect_q.size()));
        n = (seen_q.size() < expect_q.size()) ? seen_q.size() : expect_q.size();
        for (int i = 0; i < n; i++) begin
            check_req($sformatf("%s data_req[%0d]", name, i), seen_q[i], expect_q[i]);
        end
    endtask

    task automatic run_all(input logic rnd);
        random_delay = rnd;
        gap = 3;
        alu_program();
        run_program("alu spaced");
        gap = 0;
        alu_program();
        run_program("alu dense");
        branch_program();
        run_program("branch");
        memory_program();
        run_program("memory");
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        gap          = 0;
        random_delay = 1'b0;
        done_seen    = 1'b0;
        lfsr         = 16'd26821;
        run_all(1'b0);
        run_all(1'b1); // same programs with random port delays.
        $display("errors: %0d of %0d checks failed", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the programs finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
verif/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*) $(wildcard verif/*)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
